// File: source/rast_pkg.sv
// Rasterizer shared definitions
// Fixed-point coordinate format, colour channel type, edge function
// type and the sub-sample code used by every pipeline stage
package rast_pkg;

    // Coordinate format, RADIX fraction bits so one pixel is 16 units
    localparam int SIGFIG = 16;
    localparam int RADIX  = 4;

    // Colour channels
    localparam int COLOR_BITS = 8;
    localparam int NUM_COLORS = 3;   // Default channel count at the top

    // Screen-space coordinate
    typedef logic signed [SIGFIG-1:0] coord_t;

    // One colour channel
    typedef logic [COLOR_BITS-1:0] color_t;

    // Edge function value
    // Double width keeps the cross products exact
    typedef logic signed [2*SIGFIG-1:0] edge_t;

    // Sub-sample code c selects a step of 2**(RADIX-c) units
    // 0 is one pixel, 3 is an eighth of a pixel
    typedef logic [1:0] sub_code_t;

endpackage

// File: source/bbox_setup.sv
// Bounding box setup
// Finds the vertex extremes of the incoming triangle, snaps them to the
// sample grid, clips them to the screen and culls empty boxes. The box is
// held with the triangle and colour until the sample iterator takes it.
`timescale 1ns/10ps

module bbox_setup import rast_pkg::*; #(
    parameter int COLORS = NUM_COLORS
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      tri_valid,
    input  coord_t    tri_x [3],
    input  coord_t    tri_y [3],
    input  color_t    tri_color [COLORS],
    input  coord_t    screen_w,
    input  coord_t    screen_h,
    input  sub_code_t sub_sample,
    input  logic      iter_ready,
    output logic      halt,
    output logic      box_valid,
    output coord_t    box_x_min,
    output coord_t    box_x_max,
    output coord_t    box_y_min,
    output coord_t    box_y_max,
    output coord_t    box_tri_x [3],
    output coord_t    box_tri_y [3],
    output color_t    box_color [COLORS]
);

    coord_t step;
    coord_t snap_mask;
    coord_t x_lo, x_hi, y_lo, y_hi;         // Raw vertex extremes
    coord_t x_min_c, x_max_c;
    coord_t y_min_c, y_max_c;
    coord_t scr_w_snap, scr_h_snap;
    logic   culled;
    logic   take;

    assign step      = coord_t'(1 << (RADIX - sub_sample));
    assign snap_mask = ~(step - coord_t'(1));   // Clears sub-step bits

    always_comb begin
        x_lo = tri_x[0];
        x_hi = tri_x[0];
        y_lo = tri_y[0];
        y_hi = tri_y[0];
        for (int i = 1; i < 3; i++) begin
            if (tri_x[i] < x_lo) x_lo = tri_x[i];
            if (tri_x[i] > x_hi) x_hi = tri_x[i];
            if (tri_y[i] < y_lo) y_lo = tri_y[i];
            if (tri_y[i] > y_hi) y_hi = tri_y[i];
        end
    end

    assign scr_w_snap = screen_w & snap_mask;
    assign scr_h_snap = screen_h & snap_mask;

    // Snap down to the grid, then clip to the screen
    always_comb begin
        x_min_c = x_lo & snap_mask;
        x_max_c = x_hi & snap_mask;
        y_min_c = y_lo & snap_mask;
        y_max_c = y_hi & snap_mask;
        if (x_min_c < 0) x_min_c = '0;
        if (y_min_c < 0) y_min_c = '0;
        if (x_max_c > scr_w_snap) x_max_c = scr_w_snap;
        if (y_max_c > scr_h_snap) y_max_c = scr_h_snap;
    end

    assign culled = (x_min_c > x_max_c) || (y_min_c > y_max_c);

    // Held box drains the same cycle it reloads
    assign halt = box_valid && !iter_ready;
    assign take = tri_valid && !halt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            box_valid <= 1'b0;
        end else if (!halt) begin
            box_valid <= take && !culled;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            box_x_min <= x_min_c;
            box_x_max <= x_max_c;
            box_y_min <= y_min_c;
            box_y_max <= y_max_c;
            box_tri_x <= tri_x;
            box_tri_y <= tri_y;
            box_color <= tri_color;
        end
    end

    // A stalled triangle must wait on the inputs until it is taken
    a_tri_held: assert property (@(posedge clk) disable iff (!arst_n)
        tri_valid && halt |=> tri_valid);

endmodule

// File: source/sample_iterator.sv
// Sample iterator
// Takes one box at a time and walks it in row order at the sub-sample
// step, one sample per cycle, x fastest. Ready again in the cycle of
// the final sample so boxes can follow back to back.
`timescale 1ns/10ps

module sample_iterator import rast_pkg::*; #(
    parameter int COLORS = NUM_COLORS
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      box_valid,
    input  coord_t    box_x_min,
    input  coord_t    box_x_max,
    input  coord_t    box_y_min,
    input  coord_t    box_y_max,
    input  coord_t    box_tri_x [3],
    input  coord_t    box_tri_y [3],
    input  color_t    box_color [COLORS],
    input  sub_code_t sub_sample,
    output logic      iter_ready,
    output logic      samp_valid,
    output coord_t    samp_x,
    output coord_t    samp_y,
    output coord_t    samp_tri_x [3],
    output coord_t    samp_tri_y [3],
    output color_t    samp_color [COLORS]
);

    coord_t step;
    coord_t x_min_q;       // Row restart point
    coord_t x_max_q;
    coord_t y_min_q;
    coord_t y_max_q;
    logic   row_end;
    logic   last;
    logic   load;

    assign step = coord_t'(1 << (RADIX - sub_sample));

    // Bounds are grid aligned, so >= only trips on the exact end
    assign row_end = samp_x >= x_max_q;
    assign last    = samp_valid && row_end && (samp_y >= y_max_q);

    assign iter_ready = !samp_valid || last;
    assign load       = box_valid && iter_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            samp_valid <= 1'b0;
        end else if (load) begin
            samp_valid <= 1'b1;
        end else if (last) begin
            samp_valid <= 1'b0;
        end
    end

    // Box capture and x/y stepping
    always_ff @(posedge clk) begin
        if (load) begin
            x_min_q    <= box_x_min;
            x_max_q    <= box_x_max;
            y_min_q    <= box_y_min;
            y_max_q    <= box_y_max;
            samp_x     <= box_x_min;   // First sample at the min corner
            samp_y     <= box_y_min;
            samp_tri_x <= box_tri_x;
            samp_tri_y <= box_tri_y;
            samp_color <= box_color;
        end else if (samp_valid) begin
            if (row_end) begin
                samp_x <= x_min_q;
                samp_y <= samp_y + step;
            end else begin
                samp_x <= samp_x + step;
            end
        end
    end

    a_samp_in_box: assert property (@(posedge clk) disable iff (!arst_n)
        samp_valid |-> (samp_x >= x_min_q) && (samp_x <= x_max_q) &&
                       (samp_y >= y_min_q) && (samp_y <= y_max_q));

endmodule

// File: source/edge_test.sv
// Edge test
// Two-stage pipeline. Stage one takes the vertex offsets from the
// sample, stage two forms the three edge functions and applies the
// inside rule. Only hits leave, two cycles after the sample arrives.
// Clockwise triangles give a negative edge and never hit.
`timescale 1ns/10ps

module edge_test import rast_pkg::*; #(
    parameter int COLORS = NUM_COLORS
) (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   samp_valid,
    input  coord_t samp_x,
    input  coord_t samp_y,
    input  coord_t samp_tri_x [3],
    input  coord_t samp_tri_y [3],
    input  color_t samp_color [COLORS],
    output logic   hit_valid,
    output coord_t hit_x,
    output coord_t hit_y,
    output color_t hit_color [COLORS]
);

    // Stage one registers
    logic   s1_valid;
    coord_t s1_x;
    coord_t s1_y;
    coord_t s1_dx [3];          // Vertex minus sample
    coord_t s1_dy [3];
    color_t s1_color [COLORS];

    // Stage two combinational
    edge_t  edge_val [3];
    logic   is_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid  <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            s1_valid  <= samp_valid;
            hit_valid <= s1_valid && is_hit;   // Misses dropped here
        end
    end

    always_ff @(posedge clk) begin
        if (samp_valid) begin
            s1_x     <= samp_x;
            s1_y     <= samp_y;
            s1_color <= samp_color;
            for (int i = 0; i < 3; i++) begin
                s1_dx[i] <= samp_tri_x[i] - samp_x;
                s1_dy[i] <= samp_tri_y[i] - samp_y;
            end
        end
    end

    // Edge i runs from vertex i to vertex i+1
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            edge_val[i] = edge_t'(s1_dx[i]) * edge_t'(s1_dy[(i + 1) % 3])
                        - edge_t'(s1_dx[(i + 1) % 3]) * edge_t'(s1_dy[i]);
        end
    end

    // Edge 1 strict so shared edges are not hit twice
    assign is_hit = (edge_val[0] >= 0) && (edge_val[1] > 0) && (edge_val[2] >= 0);

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            hit_x     <= s1_x;
            hit_y     <= s1_y;
            hit_color <= s1_color;
        end
    end

endmodule

// File: source/rast_top.sv
// Triangle rasterizer top
// Box setup, sample iterator and edge test in a chain. Takes one
// triangle per accepted cycle and streams out the covered samples
// with the triangle colour.
`timescale 1ns/10ps

module rast_top import rast_pkg::*; #(
    parameter int COLORS = NUM_COLORS
) (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      tri_valid,
    input  coord_t    tri_x [3],
    input  coord_t    tri_y [3],
    input  color_t    tri_color [COLORS],
    input  coord_t    screen_w,
    input  coord_t    screen_h,
    input  sub_code_t sub_sample,
    output logic      halt,
    output logic      hit_valid,
    output coord_t    hit_x,
    output coord_t    hit_y,
    output color_t    hit_color [COLORS]
);

    // Box link
    logic   box_valid;
    logic   iter_ready;
    coord_t box_x_min, box_x_max;
    coord_t box_y_min, box_y_max;
    coord_t box_tri_x [3];
    coord_t box_tri_y [3];
    color_t box_color [COLORS];

    // Sample link, no back-pressure
    logic   samp_valid;
    coord_t samp_x, samp_y;
    coord_t samp_tri_x [3];
    coord_t samp_tri_y [3];
    color_t samp_color [COLORS];

    bbox_setup #(.COLORS(COLORS)) u_bbox (
        .clk, .arst_n, .tri_valid, .tri_x, .tri_y, .tri_color,
        .screen_w, .screen_h, .sub_sample, .iter_ready, .halt, .box_valid,
        .box_x_min, .box_x_max, .box_y_min, .box_y_max,
        .box_tri_x, .box_tri_y, .box_color
    );

    sample_iterator #(.COLORS(COLORS)) u_iter (
        .clk, .arst_n, .box_valid, .box_x_min, .box_x_max, .box_y_min,
        .box_y_max, .box_tri_x, .box_tri_y, .box_color, .sub_sample,
        .iter_ready, .samp_valid, .samp_x, .samp_y,
        .samp_tri_x, .samp_tri_y, .samp_color
    );

    edge_test #(.COLORS(COLORS)) u_edge (
        .clk, .arst_n, .samp_valid, .samp_x, .samp_y, .samp_tri_x,
        .samp_tri_y, .samp_color, .hit_valid, .hit_x, .hit_y, .hit_color
    );

endmodule

// File: include/rast_tb_model.svh
// Rasterizer reference model for the testbench
// Box rule, row-order sample walk and inside test on whole triangles.
// Expects rast_pkg to be imported by the including module.
`ifndef RAST_TB_MODEL_SVH
`define RAST_TB_MODEL_SVH

// One expected hit with the colour looked up by triangle index
typedef struct {
    coord_t x;
    coord_t y;
    int     tri_id;
} model_hit_t;

function automatic coord_t grid_step(input sub_code_t c);
    return coord_t'(1 << (RADIX - c));
endfunction

// Snapped and clipped box that returns 0 when the triangle is culled
function automatic bit clip_box(input coord_t tx [3], input coord_t ty [3],
                                input coord_t sw, input coord_t sh,
                                input sub_code_t c,
                                output coord_t x0, output coord_t x1,
                                output coord_t y0, output coord_t y1);
    coord_t mask;
    mask = ~(grid_step(c) - coord_t'(1));
    x0 = tx[0];
    x1 = tx[0];
    y0 = ty[0];
    y1 = ty[0];
    for (int i = 1; i < 3; i++) begin
        if (tx[i] < x0) x0 = tx[i];
        if (tx[i] > x1) x1 = tx[i];
        if (ty[i] < y0) y0 = ty[i];
        if (ty[i] > y1) y1 = ty[i];
    end
    x0 = x0 & mask;
    x1 = x1 & mask;
    y0 = y0 & mask;
    y1 = y1 & mask;
    if (x0 < 0) x0 = '0;
    if (y0 < 0) y0 = '0;
    if (x1 > (sw & mask)) x1 = sw & mask;
    if (y1 > (sh & mask)) y1 = sh & mask;
    return (x0 <= x1) && (y0 <= y1);
endfunction

// Edges 0 and 2 inclusive and edge 1 strict
function automatic bit is_inside(input coord_t tx [3], input coord_t ty [3],
                                 input coord_t sx, input coord_t sy);
    edge_t e [3];
    int    j;
    for (int i = 0; i < 3; i++) begin
        j = (i + 1) % 3;
        e[i] = edge_t'(coord_t'(tx[i] - sx)) * edge_t'(coord_t'(ty[j] - sy))
             - edge_t'(coord_t'(tx[j] - sx)) * edge_t'(coord_t'(ty[i] - sy));
    end
    return (e[0] >= 0) && (e[1] > 0) && (e[2] >= 0);
endfunction

// Walks the box in row order, queues the hits and returns the sample count
function automatic int walk_samples(input coord_t tx [3], input coord_t ty [3],
                                    input coord_t sw, input coord_t sh,
                                    input sub_code_t c, input int tri_id,
                                    ref model_hit_t q [$]);
    coord_t x0, x1, y0, y1;
    coord_t step;
    int     count;
    step  = grid_step(c);
    count = 0;
    if (!clip_box(tx, ty, sw, sh, c, x0, x1, y0, y1)) return 0;
    for (coord_t y = y0; y <= y1; y += step) begin
        for (coord_t x = x0; x <= x1; x += step) begin
            count++;
            if (is_inside(tx, ty, x, y)) q.push_back('{x: x, y: y, tri_id: tri_id});
        end
    end
    return count;
endfunction

`endif

// File: verification/rast_tb.sv
// Rasterizer testbench
// Random triangles from a fixed seed go through rast_top. Hits are
// compared in order with the reference model, which also sets the
// cycle limit of the run.
`timescale 1ns/10ps

module rast_tb import rast_pkg::*;;

    `include "rast_tb_model.svh"

    localparam int     NTRI   = 60;
    localparam coord_t SCREEN = 16'sd160;   // 10 pixels

    logic      clk;
    logic      arst_n;
    logic      tri_valid;
    coord_t    tri_x [3];
    coord_t    tri_y [3];
    color_t    tri_color [NUM_COLORS];
    coord_t    screen_w;
    coord_t    screen_h;
    sub_code_t sub_sample;
    logic      halt;
    logic      hit_valid;
    coord_t    hit_x;
    coord_t    hit_y;
    color_t    hit_color [NUM_COLORS];

    coord_t     vx [NTRI][3];
    coord_t     vy [NTRI][3];
    color_t     col_mem [NTRI][NUM_COLORS];   // Channel 0 holds the triangle index
    bit         no_hit [NTRI];                // Clockwise or off screen
    bit         held [NTRI];
    int         samples [NTRI];
    int         exp_cnt [NTRI];
    int         got_cnt [NTRI];
    sub_code_t  codes [NTRI / 10];
    model_hit_t exp_q [$];
    int         errs [5];
    int         cycles, limit, max_samples, halt_run, hits_seen;

    rast_top #(.COLORS(NUM_COLORS)) UUT (
        .clk, .arst_n, .tri_valid, .tri_x, .tri_y, .tri_color, .screen_w, .screen_h,
        .sub_sample, .halt, .hit_valid, .hit_x, .hit_y, .hit_color
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Run stopped after %0d cycles, hits did not finish in time", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    // In-order hit monitor on the falling edge
    always @(negedge clk) begin
        model_hit_t e;
        coord_t     mask;
        int         idx;
        halt_run = (arst_n && halt) ? halt_run + 1 : 0;
        if (halt_run == max_samples + 3) begin
            $display("halt stayed high for %0d cycles, longer than any triangle", halt_run);
            errs[2]++;
        end
        if (arst_n && hit_valid) begin
            hits_seen++;
            idx  = int'(hit_color[0]);
            mask = ~(grid_step(sub_sample) - coord_t'(1));
            if (idx < NTRI) got_cnt[idx]++;
            if (idx < NTRI && no_hit[idx]) begin
                $display("Hit from clockwise or off-screen triangle %0d", idx);
                errs[2]++;
            end
            if ((hit_x & ~mask) != 0 || hit_x < 0 || hit_x > (screen_w & mask)) begin
                $display("[ERROR] hit_x %h off grid or outside 0 to %h", hit_x, screen_w & mask);
                errs[3]++;
            end
            if ((hit_y & ~mask) != 0 || hit_y < 0 || hit_y > (screen_h & mask)) begin
                $display("[ERROR] hit_y %h off grid or outside 0 to %h", hit_y, screen_h & mask);
                errs[3]++;
            end
            if (exp_q.size() == 0) begin
                $display("Extra hit at x %h y %h with nothing expected", hit_x, hit_y);
                errs[1]++;
            end else begin
                e = exp_q.pop_front();
                if (hit_x !== e.x || hit_y !== e.y) begin
                    $display("[ERROR] hit_x/hit_y got %h/%h expected %h/%h",
                             hit_x, hit_y, e.x, e.y);
                    errs[1]++;
                end
                for (int c = 0; c < NUM_COLORS; c++) begin
                    if (hit_color[c] !== col_mem[e.tri_id][c]) begin
                        $display("[ERROR] hit_color[%0d] got %h expected %h",
                                 c, hit_color[c], col_mem[e.tri_id][c]);
                        errs[1]++;
                    end
                end
            end
        end
    end

    // Holds the triangle on the inputs until halt lets it in
    task automatic drive_triangle(input int t);
        int waited;
        waited = 0;
        void'(walk_samples(vx[t], vy[t], screen_w, screen_h, sub_sample, t, exp_q));
        tri_valid = 1'b1;
        tri_x     = vx[t];
        tri_y     = vy[t];
        tri_color = col_mem[t];
        while (halt) begin
            @(negedge clk);
            waited++;
        end
        held[t] = (waited > 0);
        @(negedge clk);            // Taken at the rising edge just passed
        tri_valid = 1'b0;
        if ($urandom_range(3) == 0) @(negedge clk);
    endtask

    // Waits out the walks still in flight, then expects an empty pipeline
    task automatic drain_pipeline(input int t);
        int p;
        p = t - 1;
        while (p > 0 && samples[p] == 0) p--;
        repeat (samples[t] + samples[p] + 4) @(negedge clk);
        if (halt || exp_q.size() != 0) begin
            $display("Pipeline not empty after triangle %0d, %0d hits missing",
                     t, exp_q.size());
            errs[1]++;
        end
    endtask

    initial begin
        model_hit_t scratch [$];
        int         area, total;
        bit         back;
        void'($urandom(32'h61a));
        arst_n = 1'b0;
        tri_valid = 1'b0;
        tri_x = '{default: '0};
        tri_y = '{default: '0};
        tri_color = '{default: '0};
        screen_w = SCREEN;
        screen_h = SCREEN;
        sub_sample = '0;
        foreach (codes[g]) codes[g] = sub_code_t'($urandom_range(3));
        for (int t = 0; t < NTRI; t++) begin
            for (int v = 0; v < 3; v++) begin
                vx[t][v] = coord_t'($urandom_range(192)) - coord_t'(32);   // -2 to 10 pixels
                vy[t][v] = coord_t'($urandom_range(192)) - coord_t'(32);
            end
            area = (int'(vx[t][1]) - vx[t][0]) * (int'(vy[t][2]) - vy[t][0])
                 - (int'(vx[t][2]) - vx[t][0]) * (int'(vy[t][1]) - vy[t][0]);
            back = ($urandom_range(4) == 0);
            if ((area < 0) != back) begin
                vx[t] = '{vx[t][0], vx[t][2], vx[t][1]};
                vy[t] = '{vy[t][0], vy[t][2], vy[t][1]};
            end
            no_hit[t] = back;
            if ($urandom_range(5) == 0) begin
                no_hit[t] = 1'b1;
                for (int v = 0; v < 3; v++) begin
                    if (t % 2 == 0) vx[t][v] -= 224;
                    else vy[t][v] -= 224;
                end
            end
            col_mem[t][0] = color_t'(t);
            for (int c = 1; c < NUM_COLORS; c++) col_mem[t][c] = color_t'($urandom_range(255));
            scratch.delete();
            samples[t] = walk_samples(vx[t], vy[t], SCREEN, SCREEN, codes[t / 10], t, scratch);
            exp_cnt[t] = scratch.size();
            total += samples[t];
            if (samples[t] > max_samples) max_samples = samples[t];
        end
        limit = total + 8 * NTRI + 200;

        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        if (halt !== 1'b0 || hit_valid !== 1'b0) begin
            $display("[ERROR] halt %h hit_valid %h expected 0 after reset", halt, hit_valid);
            errs[0]++;
        end
        $display("Reset state: %0d errors", errs[0]);

        for (int t = 0; t < NTRI; t++) begin
            if (t % 10 == 0) begin
                if (t > 0) drain_pipeline(t - 1);
                sub_sample = codes[t / 10];
            end
            drive_triangle(t);
        end
        drain_pipeline(NTRI - 1);
        $display("Hit order and values: %0d hits, %0d errors", hits_seen, errs[1]);
        $display("Culled, clockwise and halt length: %0d errors", errs[2]);
        $display("Grid and screen range: %0d errors", errs[3]);

        total = 0;
        for (int t = 0; t < NTRI; t++) begin
            if (held[t]) begin
                total++;
                if (got_cnt[t] != exp_cnt[t]) begin
                    $display("[ERROR] hit count of held triangle %0d got %h expected %h",
                             t, got_cnt[t], exp_cnt[t]);
                    errs[4]++;
                end
            end
        end
        if (total == 0) begin
            $display("No triangle was ever held back by halt");
            errs[4]++;
        end
        $display("Held triangles: %0d held, %0d errors", total, errs[4]);

        $display("Summary: %0d triangles, %0d hits, %0d errors",
                 NTRI, hits_seen, errs.sum());
        if (errs.sum() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
source/rast_pkg.sv
source/bbox_setup.sv
source/sample_iterator.sv
source/edge_test.sv
source/rast_top.sv
verification/rast_tb.sv
